// ==== cache_pkg.sv ====
package cache_pkg;

    // address and data widths
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int BEAT_W         = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_W         = BEAT_W * BEATS_PER_LINE;  // 32-byte line

    // cache geometry
    localparam int NUM_SETS   = 16;
    localparam int OFFSET_W   = 5;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;  // 23
    localparam int WORD_SEL_W = 3;   // addr bits 4:2
    localparam int BEAT_CNT_W = 2;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BEAT_W-1:0]  beat_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // cache controller
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } cache_state_e;

endpackage : cache_pkg

// ==== line_cache.sv ====
`timescale 1ns/100ps

module line_cache
    import cache_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    // client request
    input   logic       req_valid_i,
    output  logic       req_ready_o,
    input   addr_t      req_addr_i,

    // client response
    output  logic       resp_valid_o,
    input   logic       resp_ready_i,
    output  word_t      resp_data_o,

    // refill side
    output  logic       fill_req_o,
    output  addr_t      fill_addr_o,
    input   logic       fill_done_i,
    input   line_t      fill_line_i
);

    cache_state_e   state;

    // one storage entry per set
    line_t                  line_arr [NUM_SETS];
    tag_t                   tag_arr  [NUM_SETS];
    logic   [NUM_SETS-1:0]  valid_q;

    addr_t  addr_q;     // address of the request in flight
    word_t  data_q;

    tag_t                   req_tag;
    index_t                 req_index;
    logic   [WORD_SEL_W-1:0] word_sel;
    line_t                  hit_line;
    logic                   hit;

    function automatic word_t select_word(input line_t line, input logic [WORD_SEL_W-1:0] sel);
        return line[sel*WORD_W +: WORD_W];
    endfunction

    assign req_tag   = addr_q[ADDR_W-1 -: TAG_W];
    assign req_index = addr_q[OFFSET_W +: INDEX_W];
    assign word_sel  = addr_q[OFFSET_W-1 -: WORD_SEL_W];

    assign hit_line = line_arr[req_index];
    assign hit      = valid_q[req_index] && (tag_arr[req_index] == req_tag);

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            valid_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid_i) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    state <= hit ? RESPOND : REFILL;
                end
                REFILL: begin
                    if (fill_done_i) begin
                        state              <= RESPOND;
                        valid_q[req_index] <= 1'b1;
                    end
                end
                RESPOND: begin
                    if (resp_ready_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // arrays and payload
    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid_i) begin
            addr_q <= req_addr_i;
        end
        if (state == LOOKUP && hit) begin
            data_q <= select_word(hit_line, word_sel);
        end
        if (state == REFILL && fill_done_i) begin
            line_arr[req_index] <= fill_line_i;
            tag_arr[req_index]  <= req_tag;
            data_q              <= select_word(fill_line_i, word_sel);  // forward the missed word
        end
    end

    assign req_ready_o  = (state == IDLE);
    assign resp_valid_o = (state == RESPOND);
    assign resp_data_o  = data_q;

    assign fill_req_o  = (state == REFILL);
    assign fill_addr_o = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // line aligned

    // held response must not move under the client
    a_resp_held : assert property (@(posedge clk) disable iff (rst)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o))
        else $error("line_cache: response changed while held");

    // miss request stays up until the arbiter returns the line
    a_fill_held : assert property (@(posedge clk) disable iff (rst)
        fill_req_o && !fill_done_i |=> fill_req_o && $stable(fill_addr_o))
        else $error("line_cache: fill request dropped before fill_done_i");

endmodule : line_cache

// ==== refill_arbiter.sv ====
`timescale 1ns/100ps

module refill_arbiter
    import cache_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    // instruction cache miss port
    input   logic       i_fill_req_i,
    input   addr_t      i_fill_addr_i,
    output  logic       i_fill_done_o,

    // data cache miss port
    input   logic       d_fill_req_i,
    input   addr_t      d_fill_addr_i,
    output  logic       d_fill_done_o,

    output  line_t      fill_line_o,    // shared by both caches

    // burst memory read
    output  addr_t      bmem_addr_o,
    output  logic       bmem_read_o,
    input   logic       bmem_ready_i,

    // assembled line from the adapter
    input   logic       line_valid_i,
    input   line_t      line_i
);

    logic   [1:0]   grant_q;    // one-hot with bit 1 for the data cache
    logic           busy;       // burst outstanding on memory
    logic           last_d;     // data cache won the last grant
    logic           pick;
    logic           pick_d;
    addr_t          addr_q;
    line_t          line_q;

    // no new pick while a done pulse is out because the winner still shows its request
    assign pick = (grant_q == 2'b00) && !i_fill_done_o && !d_fill_done_o
                  && (i_fill_req_i || d_fill_req_i);

    always_comb begin
        if (i_fill_req_i && d_fill_req_i) begin
            pick_d = !last_d;   // alternate under contention
        end else begin
            pick_d = d_fill_req_i;
        end
    end

    assign bmem_read_o = (grant_q != 2'b00) && !busy && bmem_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q       <= 2'b00;
            busy          <= 1'b0;
            last_d        <= 1'b0;  // data cache wins the first tie
            i_fill_done_o <= 1'b0;
            d_fill_done_o <= 1'b0;
        end else begin
            i_fill_done_o <= 1'b0;
            d_fill_done_o <= 1'b0;
            if (pick) begin
                grant_q <= pick_d ? 2'b10 : 2'b01;
                last_d  <= pick_d;
            end
            if (bmem_read_o) begin
                busy <= 1'b1;
            end
            if (busy && line_valid_i) begin
                busy          <= 1'b0;
                grant_q       <= 2'b00;
                i_fill_done_o <= grant_q[0];
                d_fill_done_o <= grant_q[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pick) begin
            addr_q <= pick_d ? d_fill_addr_i : i_fill_addr_i;
        end
        if (busy && line_valid_i) begin
            line_q <= line_i;
        end
    end

    assign bmem_addr_o = addr_q;
    assign fill_line_o = line_q;

    // no second read until the outstanding line is back
    a_one_burst : assert property (@(posedge clk) disable iff (rst)
        busy && !line_valid_i |=> !bmem_read_o)
        else $error("refill_arbiter: read issued while a burst is outstanding");

    // adapter only completes a line for a burst we started
    a_line_expected : assert property (@(posedge clk) disable iff (rst)
        line_valid_i |-> busy)
        else $error("refill_arbiter: line returned with no burst outstanding");

endmodule : refill_arbiter

// ==== burst_adapter.sv ====
`timescale 1ns/100ps

module burst_adapter
    import cache_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    // beats from memory
    input   beat_t      bmem_rdata_i,
    input   logic       bmem_rvalid_i,

    // assembled line
    output  logic       line_valid_o,
    output  line_t      line_o
);

    logic   [BEAT_CNT_W-1:0]    beat_cnt;
    logic                       last_beat;
    line_t                      line_q;

    assign last_beat = bmem_rvalid_i && (beat_cnt == BEAT_CNT_W'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= last_beat;  // one cycle after the fourth beat
            if (bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + BEAT_CNT_W'(1);  // wraps after the last beat
            end
        end
    end

    // shift in from the top
    // after four beats, beat k sits at bits 64k and up
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_W-1:BEAT_W]};
        end
    end

    assign line_o = line_q;

    // memory keeps one burst outstanding, so the next burst cannot start yet
    a_no_overlap : assert property (@(posedge clk) disable iff (rst)
        line_valid_o |-> !bmem_rvalid_i)
        else $error("burst_adapter: beat arrived while line_valid_o is high");

endmodule : burst_adapter

// ==== mem_subsystem.sv ====
`timescale 1ns/100ps

module mem_subsystem
    import cache_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    // instruction client
    input   logic       i_req_valid_i,
    output  logic       i_req_ready_o,
    input   addr_t      i_req_addr_i,
    output  logic       i_resp_valid_o,
    input   logic       i_resp_ready_i,
    output  word_t      i_resp_data_o,

    // data client
    input   logic       d_req_valid_i,
    output  logic       d_req_ready_o,
    input   addr_t      d_req_addr_i,
    output  logic       d_resp_valid_o,
    input   logic       d_resp_ready_i,
    output  word_t      d_resp_data_o,

    // burst memory
    output  addr_t      bmem_addr_o,
    output  logic       bmem_read_o,
    input   logic       bmem_ready_i,
    input   addr_t      bmem_raddr_i,
    input   beat_t      bmem_rdata_i,
    input   logic       bmem_rvalid_i
);

    logic   i_fill_req, i_fill_done;
    addr_t  i_fill_addr;
    logic   d_fill_req, d_fill_done;
    addr_t  d_fill_addr;
    line_t  fill_line;

    logic   line_valid;
    line_t  line;
    addr_t  burst_addr_q;   // line address of the burst in flight

    line_cache icache0 (
        .clk(clk),
        .rst(rst),
        .req_valid_i(i_req_valid_i),
        .req_ready_o(i_req_ready_o),
        .req_addr_i(i_req_addr_i),
        .resp_valid_o(i_resp_valid_o),
        .resp_ready_i(i_resp_ready_i),
        .resp_data_o(i_resp_data_o),
        .fill_req_o(i_fill_req),
        .fill_addr_o(i_fill_addr),
        .fill_done_i(i_fill_done),
        .fill_line_i(fill_line)
    );

    line_cache dcache0 (
        .clk(clk),
        .rst(rst),
        .req_valid_i(d_req_valid_i),
        .req_ready_o(d_req_ready_o),
        .req_addr_i(d_req_addr_i),
        .resp_valid_o(d_resp_valid_o),
        .resp_ready_i(d_resp_ready_i),
        .resp_data_o(d_resp_data_o),
        .fill_req_o(d_fill_req),
        .fill_addr_o(d_fill_addr),
        .fill_done_i(d_fill_done),
        .fill_line_i(fill_line)
    );

    refill_arbiter arb0 (
        .clk(clk),
        .rst(rst),
        .i_fill_req_i(i_fill_req),
        .i_fill_addr_i(i_fill_addr),
        .i_fill_done_o(i_fill_done),
        .d_fill_req_i(d_fill_req),
        .d_fill_addr_i(d_fill_addr),
        .d_fill_done_o(d_fill_done),
        .fill_line_o(fill_line),
        .bmem_addr_o(bmem_addr_o),
        .bmem_read_o(bmem_read_o),
        .bmem_ready_i(bmem_ready_i),
        .line_valid_i(line_valid),
        .line_i(line)
    );

    burst_adapter adapter0 (
        .clk(clk),
        .rst(rst),
        .bmem_rdata_i(bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .line_valid_o(line_valid),
        .line_o(line)
    );

    always_ff @(posedge clk) begin
        if (bmem_read_o) begin
            burst_addr_q <= bmem_addr_o;
        end
    end

    // returning beats must belong to the read we issued
    a_raddr_match : assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> bmem_raddr_i == burst_addr_q)
        else $error("mem_subsystem: bmem_raddr_i does not match the burst in flight");

endmodule : mem_subsystem

// ==== tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD = 40   // ns
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule : tb_clock

// ==== mem_subsystem_tb.sv ====
`timescale 1ns/100ps

module mem_subsystem_tb;

    localparam int unsigned SEED       = 32'h65b3;
    localparam int          RST_CYCLES = 16;
    localparam int          STEP_LIMIT = 200;      // cycles for one directed access
    localparam int          RAND_LIMIT = 60000;
    localparam int          RAND_REQS  = 400;
    localparam logic [31:0] RAND_BASE  = 32'h0000_8000;

    logic        clk;
    logic        rst          = 1'b1;
    logic        i_req_valid  = 1'b0;
    logic        i_req_ready;
    logic [31:0] i_req_addr   = '0;
    logic        i_resp_valid;
    logic        i_resp_ready = 1'b1;
    logic [31:0] i_resp_data;
    logic        d_req_valid  = 1'b0;
    logic        d_req_ready;
    logic [31:0] d_req_addr   = '0;
    logic        d_resp_valid;
    logic        d_resp_ready = 1'b1;
    logic [31:0] d_resp_data;
    logic [31:0] bmem_addr;
    logic        bmem_read;
    logic        bmem_ready   = 1'b1;
    logic [31:0] bmem_raddr   = '0;
    logic [63:0] bmem_rdata   = '0;
    logic        bmem_rvalid  = 1'b0;

    logic [31:0] drv_i_q[$];    // requests still to be driven
    logic [31:0] drv_d_q[$];
    logic [31:0] acc_i_q[$];    // accepted, waiting for a response
    logic [31:0] acc_d_q[$];
    int          resp_cnt[2] = '{0, 0};    // index 0 is the instruction port
    int          acc_cnt[2]  = '{0, 0};
    int          acc_cyc[2]  = '{0, 0};
    int          lat[2]      = '{0, 0};
    logic [1:0]  prev_resp   = 2'b00;
    int          cycle       = 0;
    int          burst_cnt   = 0;
    int          checks      = 0;
    int          errors      = 0;
    int          timeouts    = 0;
    bit          bp_on       = 1'b0;

    // memory model state
    bit          mem_busy = 1'b0;
    int          mem_wait = 0;
    int          beat_idx = 0;
    logic [31:0] mem_line = '0;

    tb_clock #(.PERIOD(40)) clkgen0 (.clk_o(clk));

    mem_subsystem dut0 (
        .clk(clk),
        .rst(rst),
        .i_req_valid_i(i_req_valid),
        .i_req_ready_o(i_req_ready),
        .i_req_addr_i(i_req_addr),
        .i_resp_valid_o(i_resp_valid),
        .i_resp_ready_i(i_resp_ready),
        .i_resp_data_o(i_resp_data),
        .d_req_valid_i(d_req_valid),
        .d_req_ready_o(d_req_ready),
        .d_req_addr_i(d_req_addr),
        .d_resp_valid_o(d_resp_valid),
        .d_resp_ready_i(d_resp_ready),
        .d_resp_data_o(d_resp_data),
        .bmem_addr_o(bmem_addr),
        .bmem_read_o(bmem_read),
        .bmem_ready_i(bmem_ready),
        .bmem_raddr_i(bmem_raddr),
        .bmem_rdata_i(bmem_rdata),
        .bmem_rvalid_i(bmem_rvalid)
    );

    // memory contents with one word per 4-aligned byte address
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return addr ^ 32'hc0de0000;
    endfunction

    function automatic logic [31:0] random_addr();
        return RAND_BASE + ($urandom_range(511, 0) << 2);  // 2 KB of words
    endfunction

    // a burst must fetch the line of a request that still waits
    function automatic bit miss_pending(input logic [31:0] line_addr);
        bit found;
        found = 1'b0;
        if (acc_i_q.size() > 0 && {acc_i_q[0][31:5], 5'b0} == line_addr) begin
            found = 1'b1;
        end
        if (acc_d_q.size() > 0 && {acc_d_q[0][31:5], 5'b0} == line_addr) begin
            found = 1'b1;
        end
        return found;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic wait_responses(input int port, input int target, input int limit);
        int n;
        n = 0;
        while (resp_cnt[port] < target && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (resp_cnt[port] < target) begin
            $display("timeout on port %0d waiting for response %0d", port, target);
            timeouts++;
        end
    endtask

    task automatic push_request(input int port, input logic [31:0] addr);
        if (port == 0) begin
            drv_i_q.push_back(addr);
        end else begin
            drv_d_q.push_back(addr);
        end
    endtask

    // one access with latency and burst count checked against hit or miss
    task automatic access(input int port, input logic [31:0] addr, input bit hit);
        int target;
        int bursts;
        target = resp_cnt[port] + 1;
        bursts = burst_cnt;
        push_request(port, addr);
        wait_responses(port, target, STEP_LIMIT);
        if (hit) begin
            check_eq(lat[port], 2, "hit latency in cycles");
            check_eq(burst_cnt, bursts, "bursts issued on a hit");
        end else begin
            check_eq(burst_cnt, bursts + 1, "bursts issued on a miss");
        end
    endtask

    // instruction client
    always @(posedge clk) begin
        if (!rst) begin
            if (!i_req_valid || i_req_ready) begin
                if (drv_i_q.size() > 0) begin
                    i_req_valid <= 1'b1;
                    i_req_addr  <= drv_i_q.pop_front();
                end else begin
                    i_req_valid <= 1'b0;
                end
            end
            i_resp_ready <= bp_on ? ($urandom_range(3, 0) != 0) : 1'b1;
        end
    end

    // data client
    always @(posedge clk) begin
        if (!rst) begin
            if (!d_req_valid || d_req_ready) begin
                if (drv_d_q.size() > 0) begin
                    d_req_valid <= 1'b1;
                    d_req_addr  <= drv_d_q.pop_front();
                end else begin
                    d_req_valid <= 1'b0;
                end
            end
            d_resp_ready <= bp_on ? ($urandom_range(3, 0) != 0) : 1'b1;
        end
    end

    // tracks accepted requests and checks every response
    always @(posedge clk) begin
        logic [31:0] exp_addr;
        if (!rst) begin
            cycle++;
            if (i_req_valid && i_req_ready) begin
                acc_i_q.push_back(i_req_addr);
                acc_cnt[0]++;
                acc_cyc[0] = cycle;
            end
            if (d_req_valid && d_req_ready) begin
                acc_d_q.push_back(d_req_addr);
                acc_cnt[1]++;
                acc_cyc[1] = cycle;
            end
            if (i_resp_valid && !prev_resp[0]) begin
                lat[0] = cycle - acc_cyc[0];
            end
            if (d_resp_valid && !prev_resp[1]) begin
                lat[1] = cycle - acc_cyc[1];
            end
            if (i_resp_valid && i_resp_ready) begin
                resp_cnt[0]++;
                if (acc_i_q.size() == 0) begin
                    errors++;
                    $display("instruction port returned a response with no request pending");
                end else begin
                    exp_addr = acc_i_q.pop_front();
                    check_eq(i_resp_data, expected_word(exp_addr), "instruction port data");
                end
            end
            if (d_resp_valid && d_resp_ready) begin
                resp_cnt[1]++;
                if (acc_d_q.size() == 0) begin
                    errors++;
                    $display("data port returned a response with no request pending");
                end else begin
                    exp_addr = acc_d_q.pop_front();
                    check_eq(d_resp_data, expected_word(exp_addr), "data port data");
                end
            end
            prev_resp = {d_resp_valid, i_resp_valid};
        end
    end

    // burst memory model with one read outstanding
    always @(posedge clk) begin
        logic [31:0] beat_addr;
        if (!rst) begin
            bmem_rvalid <= 1'b0;
            if (bmem_read) begin
                check_eq(32'(mem_busy), 32'h0, "read issued with a burst outstanding");
                check_eq(32'(bmem_ready), 32'h1, "read issued while memory not ready");
                check_eq(bmem_addr & 32'h1f, 32'h0, "burst address line aligned");
                check_eq(32'(miss_pending(bmem_addr)), 32'h1, "burst address of a waiting miss");
                mem_line = bmem_addr;
                mem_wait = int'($urandom_range(8, 2)) - 1;
                beat_idx = 0;
                mem_busy = 1'b1;
                burst_cnt++;
            end else if (mem_busy) begin
                if (mem_wait > 0) begin
                    mem_wait--;
                end else begin
                    beat_addr = mem_line + beat_idx * 8;
                    bmem_rvalid <= 1'b1;
                    bmem_raddr  <= {beat_addr[31:5], 5'b0};
                    bmem_rdata  <= {expected_word(beat_addr + 4), expected_word(beat_addr)};
                    beat_idx++;
                    mem_wait = int'($urandom_range(2, 0));  // gap before next beat
                    if (beat_idx == 4) begin
                        mem_busy = 1'b0;
                    end
                end
            end
            bmem_ready <= mem_busy ? ($urandom_range(1, 0) == 1) : 1'b1;
        end
    end

    initial begin
        int base_i;
        int base_d;
        void'($urandom(SEED));
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // no responses or reads and both ports ready after reset
        repeat (20) begin
            @(negedge clk);
            check_eq(32'({i_resp_valid, d_resp_valid, bmem_read, i_req_ready, d_req_ready}),
                     32'b00011, "idle outputs after reset");
        end

        access(0, 32'h0000_0100, 1'b0);    // cold misses
        access(1, 32'h0000_2200, 1'b0);
        access(0, 32'h0000_0104, 1'b1);    // same lines again
        access(1, 32'h0000_221c, 1'b1);
        access(0, 32'h0000_0100, 1'b1);

        // both ports miss together
        base_i = burst_cnt;
        push_request(0, 32'h0000_0400);
        push_request(1, 32'h0000_3460);
        wait_responses(0, resp_cnt[0] + 1, STEP_LIMIT);
        wait_responses(1, resp_cnt[1] + 1, STEP_LIMIT);
        check_eq(burst_cnt, base_i + 2, "bursts for two simultaneous misses");

        // same index and different tags so each one evicts the other
        for (int n = 0; n < 6; n++) begin
            access(1, n[0] ? 32'h0000_5040 : 32'h0000_1040, 1'b0);
        end

        // random traffic with back-pressure
        base_i = resp_cnt[0];
        base_d = resp_cnt[1];
        bp_on  = 1'b1;
        for (int n = 0; n < RAND_REQS; n++) begin
            push_request(0, random_addr());
            push_request(1, random_addr());
        end
        wait_responses(0, base_i + RAND_REQS, RAND_LIMIT);
        wait_responses(1, base_d + RAND_REQS, RAND_LIMIT);
        bp_on = 1'b0;
        repeat (20) @(negedge clk);    // room for a stray extra response
        check_eq(resp_cnt[0], base_i + RAND_REQS, "instruction responses");
        check_eq(resp_cnt[1], base_d + RAND_REQS, "data responses");
        check_eq(acc_cnt[0], resp_cnt[0], "instruction accepted against responses");
        check_eq(acc_cnt[1], resp_cnt[1], "data accepted against responses");
        check_eq(acc_i_q.size() + acc_d_q.size(), 0, "requests left without response");

        finish_run();
    end

endmodule : mem_subsystem_tb

// ==== vlog.f ====
cache_pkg.sv
line_cache.sv
refill_arbiter.sv
burst_adapter.sv
mem_subsystem.sv
tb_clock.sv
mem_subsystem_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= mem_subsystem_tb
FILELIST ?= vlog.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qxF -- '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
